//--- fadd.sv
`timescale 1ns/1ps

module fadd (
    input  logic              clk,
    input  logic              rstn,
    input  fpu_pkg::fp_word_t x1,
    input  fpu_pkg::fp_word_t x2,
    output fpu_pkg::fp_word_t y,
    output logic              ovf
);

    // ##############################
    // stage 0: order and align
    // ##############################

    fpu_pkg::fp_word_t lx;
    fpu_pkg::fp_word_t sx;
    fpu_pkg::fp_exp_t  shift;
    logic [23:0]       sfp1;
    logic [25:0]       lf25;
    logic [25:0]       sf25;

    assign lx    = (x1[30:0] >= x2[30:0]) ? x1 : x2;   // larger magnitude.
    assign sx    = (x1[30:0] >= x2[30:0]) ? x2 : x1;
    assign shift = lx[30:23] - sx[30:23];              // never negative.

    // denormals count as zero, so no hidden bit for a zero exponent.
    assign lf25 = (lx[30:23] == '0) ? '0 : {1'b1, lx[22:0], 2'b00};
    assign sfp1 = (sx[30:23] == '0) ? '0 : {1'b1, sx[22:0]};
    assign sf25 = {sfp1, 2'b00} >> shift;              // two guard bits.

    fpu_pkg::fp_word_t lx_s1;    // first copy of the larger operand.
    logic              sub_s1;   // signs differ.
    logic [25:0]       lf25_s1;
    logic [25:0]       sf25_s1;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lx_s1   <= '0;
            sub_s1  <= 1'b0;
            lf25_s1 <= '0;
            sf25_s1 <= '0;
        end else begin
            lx_s1   <= lx;
            sub_s1  <= lx[31] ^ sx[31];
            lf25_s1 <= lf25;
            sf25_s1 <= sf25;
        end
    end

    // ##############################
    // stage 1: add and normalize
    // ##############################

    logic [26:0] af26;
    logic [4:0]  top;
    logic [26:0] norm;

    assign af26 = sub_s1 ? {1'b0, lf25_s1} - {1'b0, sf25_s1}
                         : {1'b0, lf25_s1} + {1'b0, sf25_s1};

    // leading-one position from the highest set bit.
    always_comb begin
        top = '0;
        for (int i = 0; i < 27; i++) begin
            if (af26[i]) begin
                top = 5'(i);
            end
        end
    end

    // leading one lands on bit 26 and the round bit on bit 2.
    assign norm = af26 << (5'd26 - top);

    fpu_pkg::fp_word_t lx_s2;    // second copy of the larger operand.
    logic [23:0]       afnc_s2;  // normalized significand.
    logic              inc_s2;   // round bit.
    logic [4:0]        top_s2;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lx_s2   <= '0;
            afnc_s2 <= '0;
            inc_s2  <= 1'b0;
            top_s2  <= '0;
        end else begin
            lx_s2   <= lx_s1;
            afnc_s2 <= norm[26:3];
            inc_s2  <= norm[2];
            top_s2  <= top;
        end
    end

    // ##############################
    // stage 2: round and pack
    // ##############################

    logic [24:0]        af;
    logic [4:0]         ttop;
    logic signed [9:0]  ae;
    logic               sum_zero;
    fpu_pkg::fp_frac_t  yf;

    assign af       = {1'b0, afnc_s2} + 25'(inc_s2);   // round half away from zero.
    assign ttop     = top_s2 + 5'(af[24]);             // carry out of rounding.
    assign sum_zero = ~afnc_s2[23];                    // no leading one found.
    assign yf       = af[24] ? af[23:1] : af[22:0];

    // position 25 keeps the exponent of the larger operand.
    assign ae = $signed({2'b00, lx_s2[30:23]}) + $signed({5'b00000, ttop}) - 10'sd25;

    always_comb begin
        if (lx_s2[30:23] == fpu_pkg::exp_max) begin
            y   = lx_s2;                               // inf or nan passes through.
            ovf = 1'b0;
        end else if (sum_zero) begin
            y   = {lx_s2[31], 31'b0};
            ovf = 1'b0;
        end else if (ae >= fpu_pkg::exp_max) begin
            y   = {lx_s2[31], 8'hff, 23'b0};           // signed infinity.
            ovf = 1'b1;
        end else if (ae <= 0) begin
            y   = {lx_s2[31], 31'b0};                  // below smallest normal.
            ovf = 1'b1;
        end else begin
            y   = {lx_s2[31], fpu_pkg::fp_exp_t'(ae[7:0]), yf};
            ovf = 1'b0;
        end
    end

endmodule

//--- fmul.sv
`timescale 1ns/1ps

module fmul (
    input  logic              clk,
    input  logic              rstn,
    input  fpu_pkg::fp_word_t x1,
    input  fpu_pkg::fp_word_t x2,
    output fpu_pkg::fp_word_t y,
    output logic              ovf
);

    // ##############################
    // stage 0: sign and exponent
    // ##############################

    logic              zero;
    logic signed [9:0] esum;

    assign zero = (x1[30:23] == '0) || (x2[30:23] == '0);   // denormal is zero.
    assign esum = $signed({2'b00, x1[30:23]}) + $signed({2'b00, x2[30:23]})
                - 10'(fpu_pkg::exp_bias);

    logic              sign_s1;
    logic              zero_s1;
    logic signed [9:0] exp_s1;
    logic [23:0]       ma_s1;    // significands with hidden bit.
    logic [23:0]       mb_s1;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            sign_s1 <= 1'b0;
            zero_s1 <= 1'b1;     // idle pipe reads as zero.
            exp_s1  <= '0;
            ma_s1   <= '0;
            mb_s1   <= '0;
        end else begin
            sign_s1 <= x1[31] ^ x2[31];
            zero_s1 <= zero;
            exp_s1  <= esum;
            ma_s1   <= {1'b1, x1[22:0]};
            mb_s1   <= {1'b1, x2[22:0]};
        end
    end

    // ##############################
    // stage 1: product and normalize
    // ##############################

    logic [47:0] prod;
    logic        top;

    assign prod = ma_s1 * mb_s1;
    assign top  = prod[47];      // product in [1, 4).

    logic              sign_s2;
    logic              zero_s2;
    logic signed [9:0] exp_s2;
    logic [23:0]       mant_s2;
    logic              rnd_s2;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            sign_s2 <= 1'b0;
            zero_s2 <= 1'b1;
            exp_s2  <= '0;
            mant_s2 <= '0;
            rnd_s2  <= 1'b0;
        end else begin
            sign_s2 <= sign_s1;
            zero_s2 <= zero_s1;
            exp_s2  <= exp_s1 + 10'(top);
            mant_s2 <= top ? prod[47:24] : prod[46:23];
            rnd_s2  <= top ? prod[23] : prod[22];
        end
    end

    // ##############################
    // stage 2: round and pack
    // ##############################

    logic [24:0]        m;
    logic signed [9:0]  ae;
    fpu_pkg::fp_frac_t  yf;

    assign m  = {1'b0, mant_s2} + 25'(rnd_s2);
    assign ae = exp_s2 + 10'(m[24]);                  // renormalize on carry.
    assign yf = m[24] ? m[23:1] : m[22:0];

    always_comb begin
        if (zero_s2) begin
            y   = {sign_s2, 31'b0};                   // exact zero.
            ovf = 1'b0;
        end else if (ae >= fpu_pkg::exp_max) begin
            y   = {sign_s2, 8'hff, 23'b0};
            ovf = 1'b1;
        end else if (ae <= 0) begin
            y   = {sign_s2, 31'b0};
            ovf = 1'b1;
        end else begin
            y   = {sign_s2, fpu_pkg::fp_exp_t'(ae[7:0]), yf};
            ovf = 1'b0;
        end
    end

endmodule

//--- fpu.sv
`timescale 1ns/1ps

module fpu (
    input  logic              clk,
    input  logic              rstn,
    input  fpu_pkg::fpu_op_t  op,
    input  fpu_pkg::fp_word_t x1,
    input  fpu_pkg::fp_word_t x2,
    output fpu_pkg::fp_word_t y,
    output logic              ovf
);

    fpu_pkg::fp_word_t add_x1;
    fpu_pkg::fp_word_t add_x2;
    fpu_pkg::fp_word_t add_y;
    logic              add_ovf;
    fpu_pkg::fp_word_t mul_y;
    logic              mul_ovf;

    // decode, delay the code and pick the result.
    fpu_op_pipe op_pipe_i (
        .clk     (clk),
        .rstn    (rstn),
        .op      (op),
        .x1      (x1),
        .x2      (x2),
        .add_x1  (add_x1),
        .add_x2  (add_x2),
        .add_y   (add_y),
        .add_ovf (add_ovf),
        .mul_y   (mul_y),
        .mul_ovf (mul_ovf),
        .y       (y),
        .ovf     (ovf)
    );

    // both units run every cycle.
    fadd fadd_i (
        .clk  (clk),
        .rstn (rstn),
        .x1   (add_x1),
        .x2   (add_x2),
        .y    (add_y),
        .ovf  (add_ovf)
    );

    fmul fmul_i (
        .clk  (clk),
        .rstn (rstn),
        .x1   (x1),           // raw operands.
        .x2   (x2),
        .y    (mul_y),
        .ovf  (mul_ovf)
    );

endmodule

//--- fpu_chk.sv
`timescale 1ns/1ps

module fpu_chk (
    input logic              clk,
    input logic              rstn,
    input fpu_pkg::fpu_op_t  op,
    input fpu_pkg::fp_word_t x1,
    input fpu_pkg::fp_word_t y,
    input logic              ovf
);

    // ##############################
    // reset release
    // ##############################

    // reset values still drain out on the first two edges.
    a_release_zero: assert property (@(posedge clk)
        (rstn && (!$past(rstn) || !$past(rstn, 2))) |-> (y == '0 && !ovf))
        else $error("y or ovf not zero right after reset release");

    // ##############################
    // result range
    // ##############################

    a_ovf_exp: assert property (@(posedge clk) disable iff (!rstn)
        ovf |-> (y[30:23] == '0 || y[30:23] == fpu_pkg::fp_exp_t'(fpu_pkg::exp_max)))
        else $error("ovf set with a finite nonzero exponent");

    // zero or denormal multiplicand gives a zero result.
    a_mul_zero: assert property (@(posedge clk) disable iff (!rstn)
        ($past(op, fpu_pkg::fpu_latency) == fpu_pkg::op_mul &&
         $past(x1[30:23], fpu_pkg::fpu_latency) == '0) |-> (y[30:23] == '0))
        else $error("multiply by zero gave a nonzero exponent");

endmodule

bind fpu fpu_chk fpu_chk_i (
    .clk  (clk),
    .rstn (rstn),
    .op   (op),
    .x1   (x1),
    .y    (y),
    .ovf  (ovf)
);

//--- fpu_op_pipe.sv
`timescale 1ns/1ps

module fpu_op_pipe (
    input  logic              clk,
    input  logic              rstn,
    input  fpu_pkg::fpu_op_t  op,
    input  fpu_pkg::fp_word_t x1,
    input  fpu_pkg::fp_word_t x2,
    output fpu_pkg::fp_word_t add_x1,
    output fpu_pkg::fp_word_t add_x2,
    input  fpu_pkg::fp_word_t add_y,
    input  logic              add_ovf,
    input  fpu_pkg::fp_word_t mul_y,
    input  logic              mul_ovf,
    output fpu_pkg::fp_word_t y,
    output logic              ovf
);

    // ##############################
    // operand conditioning
    // ##############################

    // subtract is add with the second sign flipped.
    assign add_x1 = x1;
    assign add_x2 = (op == fpu_pkg::op_sub) ? {~x2[31], x2[30:0]} : x2;

    // ##############################
    // code delay and result select
    // ##############################

    fpu_pkg::fpu_op_t op_q [fpu_pkg::fpu_latency];   // one entry per unit stage.
    logic             sel_mul;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < fpu_pkg::fpu_latency; i++) begin
                op_q[i] <= fpu_pkg::op_add;
            end
        end else begin
            op_q[0] <= op;
            for (int i = 1; i < fpu_pkg::fpu_latency; i++) begin
                op_q[i] <= op_q[i-1];
            end
        end
    end

    // codes other than mul take the adder result.
    assign sel_mul = (op_q[fpu_pkg::fpu_latency-1] == fpu_pkg::op_mul);

    assign y   = sel_mul ? mul_y : add_y;
    assign ovf = sel_mul ? mul_ovf : add_ovf;

endmodule

//--- fpu_patterns.hex
// columns: op x1 x2 expected_y expected_ovf, all hex, one operation per line
// op 0 add, 1 sub, 2 mul, 3 decoded as add
0 3f800000 3f800000 40000000 0
1 40400000 3f800000 40000000 0
2 3fc00000 3fc00000 40100000 0
0 40400000 bf800000 40000000 0
1 3f800001 3f800000 34000000 0
2 40000000 40400000 40c00000 0
0 3fffffff 33800000 40000000 0
1 40490fdb 40490fdb 00000000 0
2 3ffffffe 3f800001 40000000 0
0 bfc00000 c0200000 c0800000 0
1 3f800000 40400000 c0000000 0
2 c0000000 40400000 c0c00000 0
0 7f7fffff 7f7fffff 7f800000 1
2 7f000000 c0000000 ff800000 1
1 ff7fffff 7f7fffff ff800000 1
2 80800000 3f000000 80000000 1
1 00800001 00800000 00000000 1
2 80000000 40400000 80000000 0
0 00000000 3fc00000 3fc00000 0
2 00400000 40000000 00000000 0
0 7f800000 3f800000 7f800000 0
1 3f800000 7f800000 ff800000 0
0 7fc00001 40000000 7fc00001 0
3 3f800000 40000000 40400000 0

//--- fpu_pkg.sv
package fpu_pkg;

    // ##############################
    // word and field types
    // ##############################

    typedef logic [31:0] fp_word_t;   // binary32 value.
    typedef logic [7:0]  fp_exp_t;    // biased exponent field.
    typedef logic [22:0] fp_frac_t;   // stored fraction without the hidden bit.
    typedef logic [1:0]  fpu_op_t;    // operation code.

    // ##############################
    // operation codes
    // ##############################

    // code 3 is decoded as add.
    localparam fpu_op_t op_add = 2'd0;
    localparam fpu_op_t op_sub = 2'd1;
    localparam fpu_op_t op_mul = 2'd2;

    // ##############################
    // format constants
    // ##############################

    localparam int exp_bias = 127;    // binary32 exponent bias.
    localparam int exp_max  = 255;    // all-ones exponent for inf and nan.

    // rising edges from operand sampling to a valid result.
    localparam int fpu_latency = 2;

endpackage

//--- project.f
fpu_pkg.sv
fadd.sv
fmul.sv
fpu_op_pipe.sv
fpu.sv
fpu_chk.sv
tb_fpu.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the fpu testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_fpu -f project.f -o sim_fpu
./obj_dir/sim_fpu 2>&1 | tee sim.log

if grep -qx "Test passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- tb_fpu.sv
`timescale 1ns/1ps

module tb_fpu;

    localparam int reset_cycles  = 3;
    localparam int max_patterns  = 64;
    localparam int pattern_words = 5;     // op, x1, x2, y, ovf.

    logic              clk;
    logic              rstn;
    fpu_pkg::fpu_op_t  op;
    fpu_pkg::fp_word_t x1;
    fpu_pkg::fp_word_t x2;
    fpu_pkg::fp_word_t y;
    logic              ovf;

    fpu_pkg::fp_word_t pattern_mem [max_patterns*pattern_words];
    int                num_patterns;
    int                timeout_cycles;
    int                cycle_count = 0;
    int                error_count = 0;

    // results in flight with the cycle each one is due.
    fpu_pkg::fp_word_t exp_y_q   [$];
    logic              exp_ovf_q [$];
    int                due_q     [$];
    int                idx_q     [$];

    fpu fpu_i (
        .clk  (clk),
        .rstn (rstn),
        .op   (op),
        .x1   (x1),
        .x2   (x2),
        .y    (y),
        .ovf  (ovf)
    );

    // ##############################
    // clock and timeout
    // ##############################

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout, the run did not finish within %0d cycles", timeout_cycles);
            $display("Test failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // ##############################
    // helpers
    // ##############################

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("mismatch %s: got %h, expected %h", name, got, expected);
            $display("Test failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic load_patterns();
        for (int i = 0; i < max_patterns*pattern_words; i++) begin
            pattern_mem[i] = {16'hffff, 16'(i)};  // op above 3 marks the end.
        end
        $readmemh("fpu_patterns.hex", pattern_mem);
        num_patterns = 0;
        while (num_patterns < max_patterns &&
               pattern_mem[num_patterns*pattern_words] <= 32'd3) begin
            num_patterns++;
        end
        if (num_patterns == 0) begin
            $display("no patterns could be read from fpu_patterns.hex");
            $display("Test failed");
            $fatal(1, "empty pattern file");
        end
    endtask

    task automatic drive_pattern(input int idx, input int cyc);
        int base;
        base = idx * pattern_words;
        op   = fpu_pkg::fpu_op_t'(pattern_mem[base][1:0]);
        x1   = pattern_mem[base+1];
        x2   = pattern_mem[base+2];
        exp_y_q.push_back(pattern_mem[base+3]);
        exp_ovf_q.push_back(pattern_mem[base+4][0]);
        due_q.push_back(cyc + fpu_pkg::fpu_latency);
        idx_q.push_back(idx);
    endtask

    task automatic drive_idle();
        op = fpu_pkg::op_add;
        x1 = '0;
        x2 = '0;
    endtask

    // outputs with nothing due are still the reset values.
    task automatic check_outputs(input int cyc);
        int                idx;
        fpu_pkg::fp_word_t exp_y;
        logic              exp_ovf;
        if (due_q.size() > 0 && due_q[0] == cyc) begin
            void'(due_q.pop_front());
            idx     = idx_q.pop_front();
            exp_y   = exp_y_q.pop_front();
            exp_ovf = exp_ovf_q.pop_front();
            check_value($sformatf("y (pattern %0d)", idx), y, exp_y);
            check_value($sformatf("ovf (pattern %0d)", idx), {31'b0, ovf}, {31'b0, exp_ovf});
        end else begin
            check_value("y after reset release", y, '0);
            check_value("ovf after reset release", {31'b0, ovf}, '0);
        end
    endtask

    // ##############################
    // stimulus
    // ##############################

    initial begin
        rstn = 1'b0;
        drive_idle();
        load_patterns();
        timeout_cycles = num_patterns + reset_cycles + 20;

        repeat (reset_cycles) begin
            @(posedge clk);
            #1;
            check_value("y during reset", y, '0);
            check_value("ovf during reset", {31'b0, ovf}, '0);
        end
        rstn = 1'b1;                              // released with the first operation.

        for (int c = 0; c < num_patterns + fpu_pkg::fpu_latency; c++) begin
            if (c > 0) begin
                @(posedge clk);
                #1;
            end
            check_outputs(c);
            if (c < num_patterns) begin
                drive_pattern(c, c);
            end else begin
                drive_idle();                     // drain the pipeline.
            end
        end

        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
